//--- logic/isaPkg.sv
`default_nettype none

package isaPkg;

    // ----------------------------------------
    // ISA widths
    // ----------------------------------------
    localparam int regIdxWidth = 5;                // Register number width
    localparam int opWidth     = 3;                // Instruction class code width
    localparam int numRegs     = 2 ** regIdxWidth; // 32 architectural registers

    typedef logic [regIdxWidth-1:0] regIdx;        // Register number, r0 is hardwired zero

    // ----------------------------------------
    // Instruction class
    // ----------------------------------------
    // Only what the hazard logic cares about, not the full decode
    typedef enum logic [opWidth-1:0] {
        opAlu   = 3'd0, // R-type or immediate ALU op, result goes to rd
        opLoad  = 3'd1, // lw, result goes to rt one stage late
        opStore = 3'd2, // sw, reads rs and rt, writes nothing
        opBeq   = 3'd3, // Branch if equal, resolved in ID
        opBne   = 3'd4, // Branch if not equal, resolved in ID
        opNop   = 3'd5  // Bubble
    } opcode;

endpackage

`default_nettype wire

//--- logic/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    localparam int dataWidth = 32; // Datapath word, fixes the struct widths below

    typedef logic [dataWidth-1:0] dataWord;

    // Mux select for a forwarded operand, same codes as the classic forward unit
    typedef enum logic [1:0] {
        fwdNone  = 2'd0, // Own value, register file or ID/EX latch
        fwdExMem = 2'd1, // ALU result one stage ahead
        fwdMemWb = 2'd2  // Write-back value two stages ahead
    } fwdSel;

    // ----------------------------------------
    // Stage snapshots
    // ----------------------------------------
    typedef struct packed {
        opcode op;       // Class of the instruction being decoded
        regIdx rs;
        regIdx rt;
    } ifIdInfo;

    typedef struct packed {
        opcode   op;
        regIdx   rs;
        regIdx   rt;       // Also the destination of a load
        regIdx   rd;       // Destination of an ALU op
        logic    regWrite;
        dataWord rsValue;  // Read in ID, possibly stale
        dataWord rtValue;
    } idExInfo;

    typedef struct packed {
        logic    regWrite;
        logic    isLoad;   // Result not known until MEM finishes
        regIdx   dst;
        dataWord result;   // ALU output, meaningless for a load
    } exMemInfo;

    typedef struct packed {
        logic    regWrite;
        regIdx   dst;
        dataWord data;     // Final value, ALU result or load data
    } memWbInfo;

endpackage

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  memWbInfo memWb,   // Write port, straight from write-back
    input  regIdx    rs,
    input  regIdx    rt,
    output dataWord  rsData,
    output dataWord  rtData
);

    dataWord regs [numRegs];
    logic    wrEn;

    assign wrEn = memWb.regWrite && (memWb.dst != '0); // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[memWb.dst] <= memWb.data;
        end
    end

    // Asynchronous read, same-cycle write shows the old value
    assign rsData = regs[rs];
    assign rtData = regs[rt];

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    zeroReadsZero: assert property (@(posedge clk) disable iff (rst)
        ((rs != '0) || (rsData == '0)) && ((rt != '0) || (rtData == '0)));

endmodule

`default_nettype wire

//--- logic/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  ifIdInfo  ifId,
    input  idExInfo  idEx,
    input  exMemInfo exMem,
    input  memWbInfo memWb,
    output fwdSel    fwdAId,  // Branch compare operand rs
    output fwdSel    fwdBId,  // Branch compare operand rt
    output fwdSel    fwdAEx,  // ALU operand A
    output fwdSel    fwdBEx   // ALU operand B
);

    logic isBranch;

    // Stage writes a real register that matches src
    function automatic logic hits(logic wr, regIdx dst, regIdx src);
        return wr && (dst != '0) && (dst == src);
    endfunction

    // Younger stage wins, EX/MEM holds the newer value
    function automatic fwdSel exPick(regIdx src, exMemInfo em, memWbInfo mw);
        if (hits(em.regWrite, em.dst, src))
            return fwdExMem;
        else if (hits(mw.regWrite, mw.dst, src))
            return fwdMemWb;
        return fwdNone;
    endfunction

    // Loads in EX/MEM have no data yet, hazard logic stalls the branch instead
    function automatic fwdSel idPick(regIdx src, exMemInfo em, memWbInfo mw);
        if (hits(em.regWrite, em.dst, src) && !em.isLoad)
            return fwdExMem;
        else if (hits(mw.regWrite, mw.dst, src))
            return fwdMemWb;
        return fwdNone;
    endfunction

    assign isBranch = (ifId.op == opBeq) || (ifId.op == opBne);

    // ----------------------------------------
    // EX stage, ALU operands
    // ----------------------------------------
    assign fwdAEx = exPick(idEx.rs, exMem, memWb);
    assign fwdBEx = exPick(idEx.rt, exMem, memWb);

    // ----------------------------------------
    // ID stage, early branch compare
    // ----------------------------------------
    assign fwdAId = isBranch ? idPick(ifId.rs, exMem, memWb) : fwdNone;
    assign fwdBId = isBranch ? idPick(ifId.rt, exMem, memWb) : fwdNone;

    // r0 is never a forwarding target, whichever stage claims to write it
    always_comb begin
        assert final ((idEx.rs != '0) || (fwdAEx == fwdNone));
        assert final ((idEx.rt != '0) || (fwdBEx == fwdNone));
        assert final ((ifId.rs != '0) || (fwdAId == fwdNone));
        assert final ((ifId.rt != '0) || (fwdBId == fwdNone));
        // A load result must never reach the comparator from EX/MEM
        assert final (!exMem.isLoad || ((fwdAId != fwdExMem) && (fwdBId != fwdExMem)));
    end

endmodule

`default_nettype wire

//--- logic/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

module hazardDetect
    import isaPkg::*;
    import pipePkg::*;
(
    input  ifIdInfo  ifId,
    input  idExInfo  idEx,
    input  exMemInfo exMem,
    output logic     stall   // Hold IF/ID, bubble into EX
);

    logic  isBranch;
    regIdx exDst;       // Register the EX instruction will write
    logic  loadUse;
    logic  branchHaz;

    // Nonzero register that the ID instruction reads
    function automatic logic readsReg(regIdx r, ifIdInfo id);
        return (r != '0) && ((r == id.rs) || (r == id.rt));
    endfunction

    assign isBranch = (ifId.op == opBeq) || (ifId.op == opBne);
    assign exDst    = (idEx.op == opLoad) ? idEx.rt : idEx.rd; // Loads target rt

    // ----------------------------------------
    // Load-use, data arrives after MEM
    // ----------------------------------------
    assign loadUse = (idEx.op == opLoad) && readsReg(idEx.rt, ifId);

    // ----------------------------------------
    // Branch operands not ready in ID
    // ----------------------------------------
    always_comb begin
        branchHaz = 1'b0;
        if (isBranch) begin
            if (idEx.regWrite && readsReg(exDst, ifId))
                branchHaz = 1'b1;    // ALU result only exists at the end of EX
            if (exMem.regWrite && exMem.isLoad && readsReg(exMem.dst, ifId))
                branchHaz = 1'b1;    // Load still in MEM, one more cycle
        end
    end

    assign stall = loadUse || branchHaz;

endmodule

`default_nettype wire

//--- logic/operandRouter.sv
`timescale 1ns/1ps
`default_nettype none

module operandRouter
    import isaPkg::*;
    import pipePkg::*;
(
    input  ifIdInfo  ifId,
    input  idExInfo  idEx,
    input  exMemInfo exMem,
    input  memWbInfo memWb,
    input  dataWord  rsData,      // Register file reads for ID
    input  dataWord  rtData,
    input  fwdSel    fwdAId,
    input  fwdSel    fwdBId,
    input  fwdSel    fwdAEx,
    input  fwdSel    fwdBEx,
    input  logic     stall,
    output dataWord  operandAEx,
    output dataWord  operandBEx,
    output logic     branchTaken
);

    dataWord cmpA;   // Forwarded ID compare operands
    dataWord cmpB;
    logic    cond;

    // 3:1 operand mux
    function automatic dataWord pick(fwdSel sel, dataWord own, dataWord exRes, dataWord wbData);
        case (sel)
            fwdExMem: return exRes;
            fwdMemWb: return wbData;
            default:  return own;
        endcase
    endfunction

    assign cmpA = pick(fwdAId, rsData, exMem.result, memWb.data);
    assign cmpB = pick(fwdBId, rtData, exMem.result, memWb.data);

    assign operandAEx = pick(fwdAEx, idEx.rsValue, exMem.result, memWb.data);
    assign operandBEx = pick(fwdBEx, idEx.rtValue, exMem.result, memWb.data);

    // ----------------------------------------
    // Branch resolution in ID
    // ----------------------------------------
    always_comb begin
        case (ifId.op)
            opBeq:   cond = (cmpA == cmpB);
            opBne:   cond = (cmpA != cmpB);
            default: cond = 1'b0;             // Not a branch
        endcase
    end

    assign branchTaken = cond && !stall;  // Operands may be stale while stalled

endmodule

`default_nettype wire

//--- logic/operandHazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module operandHazardUnit
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ifIdInfo  ifId,
    input  idExInfo  idEx,
    input  exMemInfo exMem,
    input  memWbInfo memWb,
    output dataWord  operandAEx,
    output dataWord  operandBEx,
    output logic     branchTaken,
    output logic     stall
);

    dataWord rsData;   // ID register reads
    dataWord rtData;
    fwdSel   fwdAId;
    fwdSel   fwdBId;
    fwdSel   fwdAEx;
    fwdSel   fwdBEx;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    regFile regFile0 (
        .clk    (clk),
        .rst    (rst),
        .memWb  (memWb),
        .rs     (ifId.rs),
        .rt     (ifId.rt),
        .rsData (rsData),
        .rtData (rtData)
    );

    // ----------------------------------------
    // Decisions
    // ----------------------------------------
    forwardUnit forwardUnit0 (
        .ifId   (ifId),
        .idEx   (idEx),
        .exMem  (exMem),
        .memWb  (memWb),
        .fwdAId (fwdAId),
        .fwdBId (fwdBId),
        .fwdAEx (fwdAEx),
        .fwdBEx (fwdBEx)
    );

    hazardDetect hazardDetect0 (
        .ifId  (ifId),
        .idEx  (idEx),
        .exMem (exMem),
        .stall (stall)
    );

    // Data muxes and branch compare
    operandRouter operandRouter0 (
        .ifId        (ifId),
        .idEx        (idEx),
        .exMem       (exMem),
        .memWb       (memWb),
        .rsData      (rsData),
        .rtData      (rtData),
        .fwdAId      (fwdAId),
        .fwdBId      (fwdBId),
        .fwdAEx      (fwdAEx),
        .fwdBEx      (fwdBEx),
        .stall       (stall),
        .operandAEx  (operandAEx),
        .operandBEx  (operandBEx),
        .branchTaken (branchTaken)
    );

endmodule

`default_nettype wire

//--- testbench/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------
// Result checks and counters
// ----------------------------------------
int errorCount = 0;   // Mismatches over the whole run
int checkCount = 0;

// Data word results, EX operands
task automatic checkWord(input dataWord got, input dataWord exp, input string what);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

// Single-bit results, stall and branchTaken
task automatic checkBit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("Mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- testbench/tbOperandHazard.sv
`timescale 1ns/1ps
`default_nettype none

module tbOperandHazard
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int numTests = 6;

    logic     clk;
    logic     rst;
    ifIdInfo  ifId;
    idExInfo  idEx;
    exMemInfo exMem;
    memWbInfo memWb;
    dataWord  operandAEx;
    dataWord  operandBEx;
    logic     branchTaken;
    logic     stall;
    int       seed = 48;
    int       testsRun = 0;
    int       testsFailed = 0;

    `include "tbChecks.svh"

    operandHazardUnit dut0 (
        .clk         (clk),
        .rst         (rst),
        .ifId        (ifId),
        .idEx        (idEx),
        .exMem       (exMem),
        .memWb       (memWb),
        .operandAEx  (operandAEx),
        .operandBEx  (operandBEx),
        .branchTaken (branchTaken),
        .stall       (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic nextCycle();
        @(posedge clk);
        #1;   // Drive just after the edge
    endtask

    task automatic settle();
        #2;   // Sample before the next edge
    endtask

    // All stages hold bubbles that write nothing
    task automatic clearStages();
        ifId  = '{op: opNop, rs: '0, rt: '0};
        idEx  = '{op: opNop, rs: '0, rt: '0, rd: '0, regWrite: 1'b0, rsValue: '0, rtValue: '0};
        exMem = '{regWrite: 1'b0, isLoad: 1'b0, dst: '0, result: '0};
        memWb = '{regWrite: 1'b0, dst: '0, data: '0};
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        testsRun++;
        if (errorCount == errsBefore) begin
            $display("%-24s ok", name);
        end else begin
            testsFailed++;
            $display("%-24s %0d errors", name, errorCount - errsBefore);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic testResetWriteBack();
        dataWord a;
        dataWord b;
        int      errs;
        errs = errorCount;
        a = $random(seed);
        b = $random(seed);
        nextCycle();
        clearStages();
        ifId = '{op: opBeq, rs: 5'd5, rt: 5'd6};
        settle();
        checkBit(branchTaken, 1'b1, "cleared registers compare equal");
        nextCycle();
        memWb = '{regWrite: 1'b1, dst: 5'd5, data: a};
        nextCycle();
        memWb = '{regWrite: 1'b1, dst: 5'd6, data: b};
        nextCycle();
        memWb = '{regWrite: 1'b1, dst: 5'd0, data: a | 32'h1};   // Must be ignored
        idEx  = '{op: opAlu, rs: 5'd5, rt: 5'd6, rd: 5'd9, regWrite: 1'b1, rsValue: a, rtValue: b};
        exMem = '{regWrite: 1'b1, isLoad: 1'b0, dst: 5'd7, result: a};
        ifId  = '{op: opBeq, rs: 5'd5, rt: 5'd7};   // r5 against a forwarded copy
        settle();
        checkWord(operandAEx, a, "operand A from ID/EX");
        checkWord(operandBEx, b, "operand B from ID/EX");
        checkBit(branchTaken, 1'b1, "r5 read back");
        nextCycle();
        memWb.regWrite = 1'b0;
        exMem.result = b;
        ifId.rs = 5'd6;
        settle();
        checkBit(branchTaken, 1'b1, "r6 read back");
        nextCycle();
        exMem.result = '0;
        ifId.rs = 5'd0;   // r0 after the write attempt
        settle();
        checkBit(branchTaken, 1'b1, "r0 still zero");
        finishTest("reset and write-back", errs);
    endtask

    task automatic testExPriority();
        dataWord x;
        dataWord y;
        dataWord rsV;
        dataWord rtV;
        int      errs;
        errs = errorCount;
        x = $random(seed);
        y = $random(seed);
        rsV = $random(seed);
        rtV = $random(seed);
        nextCycle();
        clearStages();
        idEx  = '{op: opAlu, rs: 5'd8, rt: 5'd9, rd: 5'd10, regWrite: 1'b1, rsValue: rsV, rtValue: rtV};
        exMem = '{regWrite: 1'b1, isLoad: 1'b0, dst: 5'd8, result: x};
        memWb = '{regWrite: 1'b1, dst: 5'd8, data: y};
        settle();
        checkWord(operandAEx, x, "A prefers EX/MEM");
        checkWord(operandBEx, rtV, "B not forwarded");
        nextCycle();
        exMem.regWrite = 1'b0;
        settle();
        checkWord(operandAEx, y, "A falls back to MEM/WB");
        nextCycle();
        exMem = '{regWrite: 1'b1, isLoad: 1'b0, dst: 5'd9, result: x};
        memWb = '{regWrite: 1'b1, dst: 5'd9, data: y};
        settle();
        checkWord(operandBEx, x, "B prefers EX/MEM");
        checkWord(operandAEx, rsV, "A not forwarded");
        nextCycle();
        exMem.regWrite = 1'b0;
        settle();
        checkWord(operandBEx, y, "B falls back to MEM/WB");
        finishTest("EX forwarding priority", errs);
    endtask

    task automatic testRegZero();
        dataWord rsV;
        dataWord rtV;
        int      errs;
        errs = errorCount;
        rsV = $random(seed);
        rtV = $random(seed);
        nextCycle();
        clearStages();
        idEx  = '{op: opAlu, rs: 5'd0, rt: 5'd0, rd: 5'd1, regWrite: 1'b1, rsValue: rsV, rtValue: rtV};
        exMem = '{regWrite: 1'b1, isLoad: 1'b0, dst: 5'd0, result: ~rsV};
        memWb = '{regWrite: 1'b1, dst: 5'd0, data: ~rtV};
        settle();
        checkWord(operandAEx, rsV, "A keeps r0 value");
        checkWord(operandBEx, rtV, "B keeps r0 value");
        finishTest("register zero", errs);
    endtask

    task automatic testLoadUse();
        int errs;
        errs = errorCount;
        nextCycle();
        clearStages();
        idEx = '{op: opLoad, rs: 5'd3, rt: 5'd11, rd: 5'd0, regWrite: 1'b1, rsValue: '0, rtValue: '0};
        ifId = '{op: opAlu, rs: 5'd11, rt: 5'd12};
        settle();
        checkBit(stall, 1'b1, "load rt matches ID rs");
        nextCycle();
        ifId = '{op: opAlu, rs: 5'd12, rt: 5'd11};
        settle();
        checkBit(stall, 1'b1, "load rt matches ID rt");
        nextCycle();
        ifId = '{op: opAlu, rs: 5'd12, rt: 5'd13};
        settle();
        checkBit(stall, 1'b0, "no register match");
        nextCycle();
        idEx.op = opAlu;   // Same rt, but not a load
        idEx.rd = 5'd14;
        ifId = '{op: opAlu, rs: 5'd11, rt: 5'd12};
        settle();
        checkBit(stall, 1'b0, "ALU op in EX");
        finishTest("load-use stall", errs);
    endtask

    task automatic testBranchResolve();
        dataWord v;
        dataWord w;
        int      errs;
        errs = errorCount;
        v = $random(seed);
        w = $random(seed);
        nextCycle();
        clearStages();
        ifId  = '{op: opBeq, rs: 5'd14, rt: 5'd15};
        exMem = '{regWrite: 1'b1, isLoad: 1'b0, dst: 5'd14, result: v};
        memWb = '{regWrite: 1'b1, dst: 5'd15, data: v};
        settle();
        checkBit(branchTaken, 1'b1, "beq on equal forwarded values");
        checkBit(stall, 1'b0, "no stall on forwarded branch");
        nextCycle();
        memWb.data = w;
        settle();
        checkBit(branchTaken, v == w, "beq on EX/MEM and MEM/WB values");
        nextCycle();
        ifId.op = opBne;
        settle();
        checkBit(branchTaken, v != w, "bne on EX/MEM and MEM/WB values");
        nextCycle();
        ifId.op = opAlu;
        settle();
        checkBit(branchTaken, 1'b0, "not a branch");
        finishTest("branch resolution", errs);
    endtask

    task automatic testBranchHazard();
        int errs;
        errs = errorCount;
        nextCycle();
        clearStages();
        ifId = '{op: opBeq, rs: 5'd16, rt: 5'd17};   // Both read zero, taken when free
        idEx = '{op: opAlu, rs: 5'd1, rt: 5'd2, rd: 5'd16, regWrite: 1'b1, rsValue: '0, rtValue: '0};
        settle();
        checkBit(stall, 1'b1, "EX writes branch rs");
        checkBit(branchTaken, 1'b0, "branch held while stalled");
        nextCycle();
        idEx.rd = 5'd0;
        settle();
        checkBit(stall, 1'b0, "EX writes r0");
        checkBit(branchTaken, 1'b1, "branch free again");
        nextCycle();
        idEx  = '{op: opNop, rs: '0, rt: '0, rd: '0, regWrite: 1'b0, rsValue: '0, rtValue: '0};
        exMem = '{regWrite: 1'b1, isLoad: 1'b1, dst: 5'd17, result: '0};
        settle();
        checkBit(stall, 1'b1, "load in EX/MEM feeds branch");
        checkBit(branchTaken, 1'b0, "branch held behind load");
        nextCycle();
        exMem.isLoad = 1'b0;
        settle();
        checkBit(stall, 1'b0, "ALU result in EX/MEM");
        checkBit(branchTaken, 1'b1, "branch on forwarded zero");
        finishTest("branch hazards", errs);
    endtask

    // ----------------------------------------
    // Run
    // ----------------------------------------
    initial begin
        rst = 1'b1;
        clearStages();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        testResetWriteBack();
        testExPriority();
        testRegZero();
        testLoadUse();
        testBranchResolve();
        testBranchHazard();
        $display("Tests %0d, failed %0d, checks %0d, mismatches %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Budget of 20 cycles per test
    initial begin
        repeat (numTests * 20) @(posedge clk);
        $display("Watchdog expired, the tests did not finish");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+testbench
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/forwardUnit.sv
logic/hazardDetect.sv
logic/operandRouter.sv
logic/operandHazardUnit.sv
testbench/tbOperandHazard.sv

//--- Bender.yml
package:
  name: operand_hazard_unit

sources:
  - logic/isaPkg.sv
  - logic/pipePkg.sv
  - logic/regFile.sv
  - logic/forwardUnit.sv
  - logic/hazardDetect.sv
  - logic/operandRouter.sv
  - logic/operandHazardUnit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbOperandHazard.sv
